/* src.f */
hw/video_timing_pkg.sv
hw/lut_map_pkg.sv
hw/lut_read_sequencer.sv
hw/timing_lut_ram.sv
hw/timing_param_unpack.sv
hw/video_timing_lut.sv
sim/video_timing_lut_asserts.sv
sim/tb_video_timing_lut.sv

/* Makefile */
# Verilator build and run of the video timing LUT testbench

TOP := tb_video_timing_lut
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check the log"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* sim/tb_video_timing_lut.sv */
//----------------------------------------
// testbench for the video timing LUT: loads
// random rows over the CPU port, steps through
// standards and checks the unpacked outputs
//----------------------------------------

`timescale 1ns/10ps

module tb_video_timing_lut;

  // the whole sequence takes a few hundred cycles
  localparam int MAX_CYCLES = 2000;

  logic        trn_clk;
  logic        trn_reset;
  logic [31:0] timing_std;
  logic [9:0]  timing_lut_addr;
  logic        timing_lut_we;
  logic [31:0] timing_lut_data_in;
  logic [31:0] timing_lut_data_out;
  logic [14:0] h_limit;
  logic [14:0] h_sav;
  logic [10:0] v_limit;
  logic [10:0] v1_start;
  logic [10:0] v1_end;
  logic [10:0] v2_start;
  logic [10:0] v2_end;
  logic [10:0] f1_start;
  logic [10:0] f2_start;

  logic [31:0] shadow [0:1023];
  logic [31:0] std_seq [$];
  integer      seed;
  int          cycle_count = 0;

  video_timing_lut i_video_timing_lut (.*);

  bind video_timing_lut video_timing_lut_asserts i_asserts (.*);

  initial begin
    trn_clk = 1'b0;
    forever #4 trn_clk = ~trn_clk;
  end

  //----------------------------------------
  // helpers
  //----------------------------------------
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1);
  endtask

  always @(posedge trn_clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      fail_run("timeout: the run went past its cycle limit");
    end else if (i_video_timing_lut.i_asserts.violations != 0) begin
      fail_run("a bound concurrent assertion failed");
    end
  end

  // interlace sits in bit 23 for the 1080 style interfaces and bit 22 otherwise
  function automatic logic [7:0] row_of(input logic [31:0] std);
    logic [3:0] iface;
    logic       il;
    iface = std[27:24];
    il = (iface inside {4'd5, 4'd6, 4'd9, 4'd10, 4'd11, 4'd12}) ? std[23] : std[22];
    return {iface, il, std[19:17]};
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge trn_clk);
    #1;
  endtask

  // the cycle after the write reads the same address back
  task automatic write_word(input logic [9:0] addr, input logic [31:0] data);
    @(posedge trn_clk);
    #1;
    timing_lut_addr    = addr;
    timing_lut_data_in = data;
    timing_lut_we      = 1'b1;
    shadow[addr]       = data;
    @(posedge trn_clk);
    #1;
    timing_lut_we = 1'b0;
  endtask

  task automatic load_row(input logic [31:0] std);
    for (int k = 0; k < 4; k++) begin
      write_word({row_of(std), 2'(k)}, $random(seed));
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
      else fail_run($sformatf("FAIL %s expected 0x%h got 0x%h", name, exp, got));
  endtask

  task automatic check_outputs();
    logic [7:0]  row;
    logic [31:0] w0;
    logic [31:0] w1;
    logic [31:0] w2;
    logic [31:0] w3;
    row = row_of(timing_std);
    w0 = shadow[{row, 2'd0}];
    w1 = shadow[{row, 2'd1}];
    w2 = shadow[{row, 2'd2}];
    w3 = shadow[{row, 2'd3}];
    check_value("h_limit", 32'(h_limit), {19'd0, w0[12:0]});
    check_value("h_sav", 32'(h_sav), {19'd0, w0[25:13]});
    check_value("v_limit", 32'(v_limit), {21'd0, w1[4:0], w0[31:26]});
    check_value("v1_start", 32'(v1_start), {21'd0, w1[15:5]});
    check_value("v1_end", 32'(v1_end), {21'd0, w1[26:16]});
    check_value("v2_start", 32'(v2_start), {21'd0, w2[5:0], w1[31:27]});
    check_value("v2_end", 32'(v2_end), {21'd0, w2[16:6]});
    check_value("f1_start", 32'(f1_start), {21'd0, w2[27:17]});
    check_value("f2_start", 32'(f2_start), {21'd0, w3[6:0], w2[31:28]});
  endtask

  task automatic apply_std(input logic [31:0] std);
    @(posedge trn_clk);
    #1;
    timing_std = std;
    wait_cycles(12);
    check_outputs();
  endtask

  //----------------------------------------
  // stimulus
  //----------------------------------------
  initial begin
    seed               = 32'h894d_4397;
    trn_reset          = 1'b1;
    timing_std         = 32'h0;
    timing_lut_addr    = 10'h0;
    timing_lut_we      = 1'b0;
    timing_lut_data_in = 32'h0;
    for (int i = 0; i < 1024; i++) begin
      shadow[i] = 32'h0;
    end
    // 1080 at 1.5G, then 720p, then dual link 3G and SD, with single bit toggles
    std_seq = '{32'h0584_0000, 32'h05C4_0000, 32'h0504_0000, 32'h0585_0000,
                32'h0448_0000, 32'h04C8_0000, 32'h0408_0000, 32'h0449_0000,
                32'h0A8C_0000, 32'h0100_0000, 32'h0584_0000};

    repeat (4) @(posedge trn_clk);
    #1;
    trn_reset = 1'b0;
    wait_cycles(12);
    check_outputs();

    foreach (std_seq[i]) begin
      load_row(std_seq[i]);
    end
    wait_cycles(12);
    check_outputs();

    foreach (std_seq[i]) begin
      apply_std(std_seq[i]);
    end

    // rewrite words of the selected row while the standard stays put
    write_word({row_of(timing_std), 2'd1}, $random(seed));
    wait_cycles(12);
    check_outputs();
    write_word({row_of(timing_std), 2'd3}, $random(seed));
    wait_cycles(12);
    check_outputs();

    if (i_video_timing_lut.i_asserts.violations != 0) begin
      fail_run("a bound concurrent assertion failed");
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

/* sim/video_timing_lut_asserts.sv */
//----------------------------------------
// concurrent checks on CPU read-back, the
// reset values and output stability of the
// timing LUT top, bound into the DUT by the
// testbench
//----------------------------------------

`timescale 1ns/10ps

module video_timing_lut_asserts (
  input logic                                   trn_clk,
  input logic                                   trn_reset,
  input logic [video_timing_pkg::STD_WIDTH-1:0] timing_std,
  input logic [lut_map_pkg::LUT_ADDR_WIDTH-1:0] timing_lut_addr,
  input logic                                   timing_lut_we,
  input logic [lut_map_pkg::LUT_DATA_WIDTH-1:0] timing_lut_data_in,
  input logic [lut_map_pkg::LUT_DATA_WIDTH-1:0] timing_lut_data_out,
  input logic [video_timing_pkg::H_WIDTH-1:0]   h_limit,
  input logic [video_timing_pkg::H_WIDTH-1:0]   h_sav,
  input logic [video_timing_pkg::V_WIDTH-1:0]   v_limit,
  input logic [video_timing_pkg::V_WIDTH-1:0]   v1_start,
  input logic [video_timing_pkg::V_WIDTH-1:0]   v1_end,
  input logic [video_timing_pkg::V_WIDTH-1:0]   v2_start,
  input logic [video_timing_pkg::V_WIDTH-1:0]   v2_end,
  input logic [video_timing_pkg::V_WIDTH-1:0]   f1_start,
  input logic [video_timing_pkg::V_WIDTH-1:0]   f2_start
);

  localparam int TW = 2 * video_timing_pkg::H_WIDTH + 7 * video_timing_pkg::V_WIDTH;

  localparam logic [TW-1:0] TIMING_DEF = {
    video_timing_pkg::DEF_H_LIMIT, video_timing_pkg::DEF_H_SAV,
    video_timing_pkg::DEF_V_LIMIT, video_timing_pkg::DEF_V1_START,
    video_timing_pkg::DEF_V1_END, video_timing_pkg::DEF_V2_START,
    video_timing_pkg::DEF_V2_END, video_timing_pkg::DEF_F1_START,
    video_timing_pkg::DEF_F2_START};

  int                                   violations = 0;
  logic [TW-1:0]                        timing_now;
  logic [video_timing_pkg::STD_WIDTH-1:0] std_q;
  logic [3:0]                           quiet_cycles;

  assign timing_now = {h_limit, h_sav, v_limit, v1_start, v1_end,
                       v2_start, v2_end, f1_start, f2_start};

  // counts cycles with no write and no change of the standard
  always_ff @(posedge trn_clk) begin
    std_q <= timing_std;
    if (trn_reset || timing_lut_we || (timing_std != std_q)) begin
      quiet_cycles <= 4'd0;
    end else if (quiet_cycles != 4'd15) begin
      quiet_cycles <= quiet_cycles + 4'd1;
    end
  end

  //----------------------------------------
  // properties
  //----------------------------------------
  reset_defaults: assert property (@(posedge trn_clk) trn_reset |=> timing_now == TIMING_DEF)
    else begin
      violations++;
      $error("timing outputs are not at their reset values during reset");
    end

  release_defaults: assert property (@(posedge trn_clk)
    $fell(trn_reset) |=> timing_now == TIMING_DEF)
    else begin
      violations++;
      $error("timing outputs left their reset values on the first edge after reset");
    end

  // read-first port, so the word shows up on the read that follows the write
  cpu_read_back: assert property (@(posedge trn_clk) disable iff (trn_reset)
    (!timing_lut_we && $past(timing_lut_we) && (timing_lut_addr == $past(timing_lut_addr)))
    |=> (timing_lut_data_out == $past(timing_lut_data_in, 2)))
    else begin
      violations++;
      $error("CPU read-back did not return the word just written");
    end

  outputs_stable: assert property (@(posedge trn_clk) disable iff (trn_reset)
    (quiet_cycles >= 4'd10) |-> $stable(timing_now))
    else begin
      violations++;
      $error("timing outputs changed with a stable standard and no write");
    end

endmodule

/* hw/video_timing_lut.sv */
//----------------------------------------
// video timing lookup table top: the CPU
// loads the table, the current standard
// selects the row driving the timing outputs
//----------------------------------------

`timescale 1ns/10ps

module video_timing_lut (
  input  logic                                   trn_clk,
  input  logic                                   trn_reset,
  input  logic [video_timing_pkg::STD_WIDTH-1:0] timing_std,
  input  logic [lut_map_pkg::LUT_ADDR_WIDTH-1:0] timing_lut_addr,
  input  logic                                   timing_lut_we,
  input  logic [lut_map_pkg::LUT_DATA_WIDTH-1:0] timing_lut_data_in,
  output logic [lut_map_pkg::LUT_DATA_WIDTH-1:0] timing_lut_data_out,
  output logic [video_timing_pkg::H_WIDTH-1:0]   h_limit,
  output logic [video_timing_pkg::H_WIDTH-1:0]   h_sav,
  output logic [video_timing_pkg::V_WIDTH-1:0]   v_limit,
  output logic [video_timing_pkg::V_WIDTH-1:0]   v1_start,
  output logic [video_timing_pkg::V_WIDTH-1:0]   v1_end,
  output logic [video_timing_pkg::V_WIDTH-1:0]   v2_start,
  output logic [video_timing_pkg::V_WIDTH-1:0]   v2_end,
  output logic [video_timing_pkg::V_WIDTH-1:0]   f1_start,
  output logic [video_timing_pkg::V_WIDTH-1:0]   f2_start
);

  logic [lut_map_pkg::LUT_ADDR_WIDTH-1:0] read_addr;
  logic [lut_map_pkg::LUT_DATA_WIDTH-1:0] read_data;
  lut_map_pkg::lut_phase_e                phase;

  lut_read_sequencer i_sequencer (
    .trn_clk       (trn_clk),
    .trn_reset     (trn_reset),
    .timing_std    (timing_std),
    .timing_lut_we (timing_lut_we),
    .read_addr     (read_addr),
    .phase         (phase)
  );

  // CPU side on port A, lookup side on port B
  timing_lut_ram #(
    .ADDR_WIDTH (lut_map_pkg::LUT_ADDR_WIDTH),
    .DATA_WIDTH (lut_map_pkg::LUT_DATA_WIDTH)
  ) i_ram (
    .trn_clk   (trn_clk),
    .cpu_addr  (timing_lut_addr),
    .cpu_we    (timing_lut_we),
    .cpu_wdata (timing_lut_data_in),
    .cpu_rdata (timing_lut_data_out),
    .read_addr (read_addr),
    .read_data (read_data)
  );

  timing_param_unpack i_unpack (
    .trn_clk   (trn_clk),
    .trn_reset (trn_reset),
    .phase     (phase),
    .read_data (read_data),
    .h_limit   (h_limit),
    .h_sav     (h_sav),
    .v_limit   (v_limit),
    .v1_start  (v1_start),
    .v1_end    (v1_end),
    .v2_start  (v2_start),
    .v2_end    (v2_end),
    .f1_start  (f1_start),
    .f2_start  (f2_start)
  );

endmodule

/* hw/timing_param_unpack.sv */
//----------------------------------------
// registers the lookup data and loads the
// timing values from it word by word as the
// read phases go by
//----------------------------------------

`timescale 1ns/10ps

module timing_param_unpack (
  input  logic                                      trn_clk,
  input  logic                                      trn_reset,
  input  lut_map_pkg::lut_phase_e                   phase,
  input  logic [lut_map_pkg::LUT_DATA_WIDTH-1:0]    read_data,
  output logic [video_timing_pkg::H_WIDTH-1:0]      h_limit,
  output logic [video_timing_pkg::H_WIDTH-1:0]      h_sav,
  output logic [video_timing_pkg::V_WIDTH-1:0]      v_limit,
  output logic [video_timing_pkg::V_WIDTH-1:0]      v1_start,
  output logic [video_timing_pkg::V_WIDTH-1:0]      v1_end,
  output logic [video_timing_pkg::V_WIDTH-1:0]      v2_start,
  output logic [video_timing_pkg::V_WIDTH-1:0]      v2_end,
  output logic [video_timing_pkg::V_WIDTH-1:0]      f1_start,
  output logic [video_timing_pkg::V_WIDTH-1:0]      f2_start
);

  localparam int H_PAD         = video_timing_pkg::H_WIDTH - lut_map_pkg::H_PACK_W;
  localparam int V_LIMIT_HI_W  = video_timing_pkg::V_WIDTH - lut_map_pkg::V_LIMIT_LO_W;
  localparam int V2_START_HI_W = video_timing_pkg::V_WIDTH - lut_map_pkg::V2_START_LO_W;
  localparam int F2_START_HI_W = video_timing_pkg::V_WIDTH - lut_map_pkg::F2_START_LO_W;

  logic [lut_map_pkg::LUT_DATA_WIDTH-1:0] read_q;

  // this stage lines word k up with phase PH_WORDk
  always_ff @(posedge trn_clk) begin
    read_q <= read_data;
  end

  //----------------------------------------
  // field loading
  //----------------------------------------
  always_ff @(posedge trn_clk) begin
    if (trn_reset) begin
      h_limit  <= video_timing_pkg::DEF_H_LIMIT;
      h_sav    <= video_timing_pkg::DEF_H_SAV;
      v_limit  <= video_timing_pkg::DEF_V_LIMIT;
      v1_start <= video_timing_pkg::DEF_V1_START;
      v1_end   <= video_timing_pkg::DEF_V1_END;
      v2_start <= video_timing_pkg::DEF_V2_START;
      v2_end   <= video_timing_pkg::DEF_V2_END;
      f1_start <= video_timing_pkg::DEF_F1_START;
      f2_start <= video_timing_pkg::DEF_F2_START;
    end else begin
      case (phase)
        lut_map_pkg::PH_WORD0: begin
          h_limit <= {{H_PAD{1'b0}}, read_q[lut_map_pkg::W0_H_LIMIT_LSB +: lut_map_pkg::H_PACK_W]};
          h_sav   <= {{H_PAD{1'b0}}, read_q[lut_map_pkg::W0_H_SAV_LSB +: lut_map_pkg::H_PACK_W]};
          v_limit[lut_map_pkg::V_LIMIT_LO_W-1:0] <=
            read_q[lut_map_pkg::W0_V_LIMIT_LSB +: lut_map_pkg::V_LIMIT_LO_W];
        end
        lut_map_pkg::PH_WORD1: begin
          v_limit[video_timing_pkg::V_WIDTH-1:lut_map_pkg::V_LIMIT_LO_W] <=
            read_q[lut_map_pkg::W1_V_LIMIT_LSB +: V_LIMIT_HI_W];
          v1_start <= read_q[lut_map_pkg::W1_V1_START_LSB +: video_timing_pkg::V_WIDTH];
          v1_end   <= read_q[lut_map_pkg::W1_V1_END_LSB +: video_timing_pkg::V_WIDTH];
          v2_start[lut_map_pkg::V2_START_LO_W-1:0] <=
            read_q[lut_map_pkg::W1_V2_START_LSB +: lut_map_pkg::V2_START_LO_W];
        end
        lut_map_pkg::PH_WORD2: begin
          v2_start[video_timing_pkg::V_WIDTH-1:lut_map_pkg::V2_START_LO_W] <=
            read_q[lut_map_pkg::W2_V2_START_LSB +: V2_START_HI_W];
          v2_end   <= read_q[lut_map_pkg::W2_V2_END_LSB +: video_timing_pkg::V_WIDTH];
          f1_start <= read_q[lut_map_pkg::W2_F1_START_LSB +: video_timing_pkg::V_WIDTH];
          f2_start[lut_map_pkg::F2_START_LO_W-1:0] <=
            read_q[lut_map_pkg::W2_F2_START_LSB +: lut_map_pkg::F2_START_LO_W];
        end
        // the rest of word 3 is reserved
        lut_map_pkg::PH_WORD3: begin
          f2_start[video_timing_pkg::V_WIDTH-1:lut_map_pkg::F2_START_LO_W] <=
            read_q[lut_map_pkg::W3_F2_START_LSB +: F2_START_HI_W];
        end
        default: begin
        end
      endcase
    end
  end

endmodule

/* hw/timing_lut_ram.sv */
//----------------------------------------
// timing table memory: a CPU read/write
// port and a read-only lookup port, both
// with one cycle of read latency
//----------------------------------------

`timescale 1ns/10ps

module timing_lut_ram #(
  parameter int ADDR_WIDTH = 10,
  parameter int DATA_WIDTH = 32
) (
  input  logic                  trn_clk,
  input  logic [ADDR_WIDTH-1:0] cpu_addr,
  input  logic                  cpu_we,
  input  logic [DATA_WIDTH-1:0] cpu_wdata,
  output logic [DATA_WIDTH-1:0] cpu_rdata,
  input  logic [ADDR_WIDTH-1:0] read_addr,
  output logic [DATA_WIDTH-1:0] read_data
);

  localparam int DEPTH = 1 << ADDR_WIDTH;

  logic [DATA_WIDTH-1:0] mem [0:DEPTH-1];

  // the table comes up empty and the CPU loads every row it needs
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  // port A returns the old word on the cycle of a write
  always_ff @(posedge trn_clk) begin
    if (cpu_we) begin
      mem[cpu_addr] <= cpu_wdata;
    end
    cpu_rdata <= mem[cpu_addr];
  end

  // port B is the lookup path
  always_ff @(posedge trn_clk) begin
    read_data <= mem[read_addr];
  end

endmodule

/* hw/lut_read_sequencer.sv */
//----------------------------------------
// turns the video standard into a table row
// and walks the read phases of that row
// whenever the row changes or the CPU writes
//----------------------------------------

`timescale 1ns/10ps

module lut_read_sequencer (
  input  logic                                  trn_clk,
  input  logic                                  trn_reset,
  input  logic [video_timing_pkg::STD_WIDTH-1:0] timing_std,
  input  logic                                  timing_lut_we,
  output logic [lut_map_pkg::LUT_ADDR_WIDTH-1:0] read_addr,
  output lut_map_pkg::lut_phase_e               phase
);

  video_timing_pkg::video_iface_e     iface;
  logic                               interlace;
  logic [lut_map_pkg::ROW_WIDTH-1:0] row_code;
  logic [lut_map_pkg::ROW_WIDTH-1:0] row_code_d1;
  logic                               we_d1;
  logic                               reload;

  assign iface = video_timing_pkg::video_iface_e'(timing_std[27:24]);

  // 1080 style interfaces carry the interlace flag in bit 23, the rest in bit 22
  always_comb begin
    case (iface)
      video_timing_pkg::IFACE_1080_1G5,
      video_timing_pkg::IFACE_1080_1G5_DL,
      video_timing_pkg::IFACE_1080_3G,
      video_timing_pkg::IFACE_DL_3G,
      video_timing_pkg::IFACE_1080_3G_DS,
      video_timing_pkg::IFACE_IPT: interlace = timing_std[23];
      default:                     interlace = timing_std[22];
    endcase
  end

  //----------------------------------------
  // row code and reload detection
  //----------------------------------------
  // bit 16 only picks between 1/1.001 rates, which share timing
  always_ff @(posedge trn_clk) begin
    row_code    <= {iface, interlace, timing_std[19:17]};
    row_code_d1 <= row_code;
  end

  always_ff @(posedge trn_clk) begin
    if (trn_reset) begin
      we_d1  <= 1'b0;
      reload <= 1'b0;
    end else begin
      we_d1  <= timing_lut_we;
      reload <= (row_code != row_code_d1) || we_d1;
    end
  end

  // restart the row read on reload, then step until the idle phase
  always_ff @(posedge trn_clk) begin
    if (trn_reset || reload) begin
      phase <= lut_map_pkg::PH_ADDR0;
    end else if (phase != lut_map_pkg::PH_IDLE) begin
      phase <= lut_map_pkg::lut_phase_e'(phase + 3'd1);
    end
  end

  assign read_addr = {row_code, phase[1:0]};

endmodule

/* hw/lut_map_pkg.sv */
//----------------------------------------
// layout of the timing table: address and
// data widths, the read phases and where
// each timing value sits in a row's words
//----------------------------------------

package lut_map_pkg;

  parameter int LUT_ADDR_WIDTH = 10;
  parameter int LUT_DATA_WIDTH = 32;

  // row code is interface, interlace bit, then rate bits 19..17
  parameter int ROW_WIDTH = 8;

  // the low two phase bits pick the word within a row
  typedef enum logic [2:0] {
    PH_ADDR0, PH_ADDR1,
    PH_WORD0, PH_WORD1, PH_WORD2, PH_WORD3,
    PH_TAIL, PH_IDLE
  } lut_phase_e;

  //----------------------------------------
  // packed word layout, lsb of each slice
  //----------------------------------------
  // h_limit and h_sav keep only 13 bits in the table
  parameter int H_PACK_W         = 13;
  parameter int W0_H_LIMIT_LSB   = 0;
  parameter int W0_H_SAV_LSB     = 13;
  parameter int W0_V_LIMIT_LSB   = 26;
  parameter int V_LIMIT_LO_W     = 6;
  parameter int W1_V_LIMIT_LSB   = 0;
  parameter int W1_V1_START_LSB  = 5;
  parameter int W1_V1_END_LSB    = 16;
  parameter int W1_V2_START_LSB  = 27;
  parameter int V2_START_LO_W    = 5;
  parameter int W2_V2_START_LSB  = 0;
  parameter int W2_V2_END_LSB    = 6;
  parameter int W2_F1_START_LSB  = 17;
  parameter int W2_F2_START_LSB  = 28;
  parameter int F2_START_LO_W    = 4;
  parameter int W3_F2_START_LSB  = 0;

endpackage

/* hw/video_timing_pkg.sv */
//----------------------------------------
// video timing value widths, the SMPTE 352
// interface codes and the 1080i values the
// timing outputs hold out of reset
//----------------------------------------

package video_timing_pkg;

  // width of the video standard word
  parameter int STD_WIDTH = 32;

  // horizontal values count samples, vertical and field values count lines
  parameter int H_WIDTH = 15;
  parameter int V_WIDTH = 11;

  // interface field, bits 27..24 of the standard word
  typedef enum logic [3:0] {
    IFACE_SD          = 4'd1,
    IFACE_720         = 4'd4,
    IFACE_1080_1G5    = 4'd5,
    IFACE_1080_1G5_DL = 4'd6,
    IFACE_1080_3G     = 4'd9,
    IFACE_DL_3G       = 4'd10,
    IFACE_1080_3G_DS  = 4'd11,
    IFACE_IPT         = 4'd12
  } video_iface_e;

  //----------------------------------------
  // 1080i reset values
  //----------------------------------------
  // two samples per pixel, 2200 pixels per line
  parameter logic [H_WIDTH-1:0] DEF_H_LIMIT  = 15'd4399;
  parameter logic [H_WIDTH-1:0] DEF_H_SAV    = 15'd552;
  parameter logic [V_WIDTH-1:0] DEF_V_LIMIT  = 11'd1125;
  parameter logic [V_WIDTH-1:0] DEF_V1_START = 11'd21;
  parameter logic [V_WIDTH-1:0] DEF_V1_END   = 11'd561;
  parameter logic [V_WIDTH-1:0] DEF_V2_START = 11'd584;
  parameter logic [V_WIDTH-1:0] DEF_V2_END   = 11'd1124;
  parameter logic [V_WIDTH-1:0] DEF_F1_START = 11'd1;
  parameter logic [V_WIDTH-1:0] DEF_F2_START = 11'd564;

endpackage
